// File: Bender.yml
package:
  name: uart_link

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/uart_frame_pkg.sv
      - verilog/uart_ctrl_pkg.sv
      - verilog/baud_gen.sv
      - verilog/tx_channel.sv
      - verilog/tx_arbiter.sv
      - verilog/uart_tx.sv
      - verilog/uart_rx.sv
      - verilog/uart_link.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/uart_link_tb.sv

// File: test/uart_link_tb.sv
`timescale 1ns/10ps
`include "uart_config.svh"

module uart_link_tb;
    import uart_frame_pkg::*;

    logic                          clk;
    logic                          reset;
    logic [2:0]                    baud_select;
    logic                          tx_enable;
    logic [`UART_NUM_CHANNELS-1:0] wr;
    data_byte_t                    wr_data [`UART_NUM_CHANNELS];
    logic [`UART_NUM_CHANNELS-1:0] overrun;
    logic                          txd;
    logic                          tx_busy;
    logic                          rxd;
    logic                          rx_valid;
    data_byte_t                    rx_data;
    logic                          rx_parity_err;
    logic                          rx_frame_err;

    int          errors = 0;
    int          rx_count = 0;          // rx_valid strobes seen so far
    logic        hung = 1'b0;           // Some wait ran out of time
    string       test_name;
    logic [16:0] lfsr_state = 17'd98975;
    data_byte_t  rx_got_data;           // Latched at rx_valid
    logic [1:0]  rx_got_flags;          // {frame_err, parity_err}

    uart_link uart_link_inst (
        .clk           (clk),
        .reset         (reset),
        .baud_select   (baud_select),
        .tx_enable     (tx_enable),
        .wr            (wr),
        .wr_data       (wr_data),
        .overrun       (overrun),
        .txd           (txd),
        .tx_busy       (tx_busy),
        .rxd           (rxd),
        .rx_valid      (rx_valid),
        .rx_data       (rx_data),
        .rx_parity_err (rx_parity_err),
        .rx_frame_err  (rx_frame_err)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;          // 8 ns period
    end

    // Strobe is one clock wide, so exactly one falling edge sees it
    always @(negedge clk) begin
        if (rx_valid)
            rx_count <= rx_count + 1;
    end

    // x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic draw_filler(output data_byte_t b);
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            b[i]       = lfsr_state[0];   // One step per bit
        end
    endtask

    // Clocks per oversample tick from the config header
    function automatic int baud_divisor(input logic [2:0] sel);
        case (sel)
            3'd0:    return `UART_BAUD_DIV_0;
            3'd1:    return `UART_BAUD_DIV_1;
            3'd2:    return `UART_BAUD_DIV_2;
            3'd3:    return `UART_BAUD_DIV_3;
            3'd4:    return `UART_BAUD_DIV_4;
            3'd5:    return `UART_BAUD_DIV_5;
            3'd6:    return `UART_BAUD_DIV_6;
            default: return `UART_BAUD_DIV_7;
        endcase
    endfunction

    function automatic string op_label(input int op);
        case (op)
            0:       return "single_write";
            1:       return "arbitration";
            2:       return "overrun";
            3:       return "enable";
            4:       return "rx_clean";
            5:       return "rx_parity";
            6:       return "rx_stop";
            default: return "unknown";
        endcase
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %0s %0s: expected %0h, actual %0h", test_name, what,
                     expected, actual);
            errors++;
        end
    endtask

    // One cycle of write strobes, data applied to every masked channel
    task automatic write_bytes(input logic [`UART_NUM_CHANNELS-1:0] mask,
                               input data_byte_t b0, input data_byte_t b1);
        wr         = mask;
        wr_data[0] = b0;
        wr_data[1] = b1;
        @(negedge clk);
        wr = '0;
    endtask

    // Serial monitor, returns {stop, parity, data} as seen on txd
    task automatic capture_frame(input int bit_cycles, output logic [9:0] frame);
        int waited;
        frame  = '1;
        waited = 0;
        while (txd !== 1'b0 && waited < 14 * bit_cycles) begin  // Start edge
            @(negedge clk);
            waited++;
        end
        if (txd !== 1'b0) begin
            $display("TIMEOUT in %0s: no start bit appeared on txd", test_name);
            errors++;
            hung = 1'b1;
        end else begin
            wait_cycles(bit_cycles / 2);                         // Mid start bit
            check_value("start bit", 0, txd);
            check_value("tx_busy in frame", 1, tx_busy);
            for (int b = 0; b < 10; b++) begin
                wait_cycles(bit_cycles);
                frame[b] = txd;                                  // LSB first
            end
        end
    endtask

    // Line must hold high for the whole window
    task automatic expect_quiet(input int cycles);
        int low_seen;
        low_seen = 0;
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            if (txd !== 1'b1)
                low_seen++;
        end
        check_value("idle txd low cycles", 0, low_seen);
    endtask

    // mode 1 flips parity, mode 2 sends a low stop bit
    task automatic inject_frame(input data_byte_t data, input int mode, input int bit_cycles);
        logic [10:0] bits;
        bits = {(mode == 2) ? 1'b0 : 1'b1, (^data) ^ (mode == 1), data, 1'b0};
        for (int b = 0; b < 11; b++) begin
            rxd = bits[b];
            wait_cycles(bit_cycles);
        end
        rxd = 1'b1;                     // Back to idle
    endtask

    task automatic wait_rx(input int bit_cycles);
        int waited;
        waited = 0;
        while (rx_valid !== 1'b1 && waited < 13 * bit_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (rx_valid !== 1'b1) begin
            $display("TIMEOUT in %0s: receiver never raised rx_valid", test_name);
            errors++;
            hung = 1'b1;
        end else begin
            rx_got_data  = rx_data;
            rx_got_flags = {rx_frame_err, rx_parity_err};
        end
    endtask

    initial begin
        int                            fd;
        int                            op;
        int                            chan;
        int                            baud;
        int                            bit_cycles;
        int                            err_before;
        int                            rx_before;
        int                            tests;
        data_byte_t                    data;
        data_byte_t                    exp_data;
        data_byte_t                    filler;
        data_byte_t                    second;
        logic [1:0]                    exp_flags;
        logic [9:0]                    frame;
        logic [`UART_NUM_CHANNELS-1:0] mask;
        logic [8*160-1:0]              line;

        reset       = 1'b1;
        baud_select = 3'd7;
        tx_enable   = 1'b0;
        wr          = '0;
        wr_data[0]  = '0;
        wr_data[1]  = '0;
        rxd         = 1'b1;
        tests       = 1;
        wait_cycles(4);                 // Four rising edges in reset
        reset = 1'b0;
        @(negedge clk);

        test_name = "reset";
        check_value("txd", 1, txd);
        check_value("tx_busy", 0, tx_busy);
        check_value("overrun", 0, overrun);
        check_value("rx strobes", 0, {rx_valid, rx_parity_err, rx_frame_err});
        $display("%0s: %0s", test_name, (errors == 0) ? "ok" : "errors");

        fd = $fopen("test/uart_link_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open test/uart_link_testdata.txt");
            errors++;
        end else begin
            while (!hung && $fgets(line, fd) > 0) begin
                if ($sscanf(line, "%d %d %h %d %h %b", op, chan, data, baud, exp_data,
                            exp_flags) == 6) begin          // Comment lines skipped
                    tests++;
                    err_before  = errors;
                    test_name   = $sformatf("%0s_%0d", op_label(op), tests);
                    baud_select = baud[2:0];
                    wait_cycles(20);                        // New divisor loaded
                    bit_cycles  = `UART_OS_RATIO * baud_divisor(baud[2:0]);
                    draw_filler(filler);
                    if (filler == data)
                        filler = ~data;                     // Must be distinguishable
                    mask       = '0;
                    mask[chan] = 1'b1;
                    case (op)
                        0, 2: begin
                            tx_enable = 1'b1;
                            write_bytes(mask, data, data);
                            if (op == 2)
                                write_bytes(mask, filler, filler);  // Slot still full
                            capture_frame(bit_cycles, frame);
                            check_value("frame", {1'b1, ^exp_data, exp_data}, frame);
                            expect_quiet(2 * bit_cycles);
                            check_value("overrun", exp_flags, overrun);
                        end
                        1, 3: begin
                            tx_enable = (op == 1);
                            @(negedge clk);
                            if (chan == 0)
                                write_bytes(2'b11, data, filler);
                            else
                                write_bytes(2'b11, filler, data);
                            if (op == 3) begin
                                expect_quiet(2 * bit_cycles);   // Held while disabled
                                tx_enable = 1'b1;
                            end
                            capture_frame(bit_cycles, frame);
                            check_value("first frame", {1'b1, ^exp_data, exp_data}, frame);
                            second = (exp_data == data) ? filler : data;
                            capture_frame(bit_cycles, frame);
                            check_value("second frame", {1'b1, ^second, second}, frame);
                            expect_quiet(2 * bit_cycles);
                            check_value("overrun", exp_flags, overrun);
                        end
                        4, 5, 6: begin
                            rx_before = rx_count;
                            fork
                                inject_frame(data, op - 4, bit_cycles);
                                wait_rx(bit_cycles);
                            join
                            wait_cycles(bit_cycles);
                            check_value("rx_data", exp_data, rx_got_data);
                            check_value("rx flags", exp_flags, rx_got_flags);
                            check_value("rx_valid count", 1, rx_count - rx_before);
                        end
                        default: begin
                            $display("unknown operation %0d in test data", op);
                            errors++;
                        end
                    endcase
                    if (errors == err_before)
                        $display("%0s: ok", test_name);
                    else
                        $display("%0s: %0d errors", test_name, errors - err_before);
                end
            end
            $fclose(fd);
        end

        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end
endmodule

// File: test/uart_link_testdata.txt
# op: 0 write, 1 write both, 2 overrun, 3 write both while disabled, 4 rx clean, 5 rx bad parity, 6 rx low stop
# op chan byte(hex) baud_select exp_byte(hex) exp_flags(bin: overrun[1:0] or {frame_err,parity_err})
0 0 a5 7 a5 00
0 1 3c 3 3c 00
1 0 5a 7 5a 00
1 0 69 6 69 00
0 0 81 6 81 00
1 1 c3 7 c3 00
3 1 96 5 96 00
2 1 4b 7 4b 10
0 0 00 0 00 10
1 1 f0 7 f0 10
4 0 5d 7 5d 00
4 0 ff 2 ff 00
5 0 33 7 33 01
6 0 e7 4 e7 10
4 0 12 1 12 00

// File: verilog/baud_gen.sv
`timescale 1ns/10ps
`include "uart_config.svh"

module baud_gen (
    input  logic       clk,
    input  logic       reset,
    input  logic [2:0] baud_select,    // Divisor table index
    output logic       os_tick         // One clock wide, 16x bit rate
);
    logic [7:0] divisor;               // Table entry for baud_select
    logic [7:0] count;                 // Clocks left until tick

    // Divisor table
    always_comb begin
        case (baud_select)
            3'd0:    divisor = `UART_BAUD_DIV_0;
            3'd1:    divisor = `UART_BAUD_DIV_1;
            3'd2:    divisor = `UART_BAUD_DIV_2;
            3'd3:    divisor = `UART_BAUD_DIV_3;
            3'd4:    divisor = `UART_BAUD_DIV_4;
            3'd5:    divisor = `UART_BAUD_DIV_5;
            3'd6:    divisor = `UART_BAUD_DIV_6;
            default: divisor = `UART_BAUD_DIV_7;
        endcase
    end

    // Down counter, new rate picked up only at reload
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count   <= '0;
            os_tick <= 1'b0;
        end else if (count == 8'd0) begin
            count   <= divisor - 8'd1;     // Reload for next period
            os_tick <= 1'b1;
        end else begin
            count   <= count - 8'd1;
            os_tick <= 1'b0;
        end
    end
endmodule

// File: verilog/tx_arbiter.sv
`timescale 1ns/10ps
`include "uart_config.svh"

module tx_arbiter (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [`UART_NUM_CHANNELS-1:0]  full,       // Slot occupied, per channel
    input  uart_frame_pkg::data_byte_t     held_data [`UART_NUM_CHANNELS],
    input  logic                           tx_ready,   // Transmitter idle
    output logic [`UART_NUM_CHANNELS-1:0]  grant,      // One-cycle strobe
    output logic                           tx_load,
    output uart_frame_pkg::data_byte_t     tx_data
);
    import uart_ctrl_pkg::*;

    chan_idx_t last_grant;         // Most recently served channel
    chan_idx_t pick;               // Winner this cycle
    chan_idx_t cand;               // Channel under test in the scan
    logic      found;              // Some slot is full

    // Scan starting just after the last winner
    always_comb begin
        pick  = last_grant;
        found = 1'b0;
        cand  = last_grant;
        for (int i = 1; i <= `UART_NUM_CHANNELS; i++) begin
            cand = chan_idx_t'((int'(last_grant) + i) % `UART_NUM_CHANNELS);
            if (!found && full[cand]) begin
                pick  = cand;
                found = 1'b1;
            end
        end
    end

    assign tx_load = tx_ready & found;
    assign tx_data = held_data[pick];   // Only meaningful with tx_load

    always_comb begin
        grant = '0;
        if (tx_load)
            grant[pick] = 1'b1;
    end

    // Start at the top so channel 0 wins first
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            last_grant <= chan_idx_t'(`UART_NUM_CHANNELS - 1);
        else if (tx_load)
            last_grant <= pick;
    end
endmodule

// File: verilog/tx_channel.sv
`timescale 1ns/10ps

module tx_channel (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     wr,          // Host write strobe
    input  uart_frame_pkg::data_byte_t wr_data,
    input  logic                     grant,       // Slot taken by transmitter
    output logic                     full,
    output uart_frame_pkg::data_byte_t held_data,
    output logic                     overrun      // Sticky, write hit a full slot
);
    logic accept;                  // Write lands in an empty slot

    assign accept = wr & ~full;

    // Slot state and overrun flag
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            full    <= 1'b0;
            overrun <= 1'b0;
        end else begin
            if (wr && full)
                overrun <= 1'b1;   // Byte dropped, grant same cycle too
            if (accept)
                full <= 1'b1;
            else if (grant)
                full <= 1'b0;      // Byte moved to transmitter
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (accept)
            held_data <= wr_data;
    end
endmodule

// File: verilog/uart_config.svh
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// Peer host channels sharing the one transmitter
`define UART_NUM_CHANNELS 2

// Oversample ticks per serial bit
`define UART_OS_RATIO 16

// Clocks per oversample tick, indexed by baud_select
// Kept small so a frame fits in a short simulation
`define UART_BAUD_DIV_0 8'd8    // Slowest rate
`define UART_BAUD_DIV_1 8'd7
`define UART_BAUD_DIV_2 8'd6
`define UART_BAUD_DIV_3 8'd5
`define UART_BAUD_DIV_4 8'd4
`define UART_BAUD_DIV_5 8'd3
`define UART_BAUD_DIV_6 8'd2
`define UART_BAUD_DIV_7 8'd1    // One tick per clock

`endif

// File: verilog/uart_ctrl_pkg.sv
`include "uart_config.svh"

package uart_ctrl_pkg;

    // Index of one host channel
    typedef logic [$clog2(`UART_NUM_CHANNELS)-1:0] chan_idx_t;

    // Transmitter FSM
    typedef enum logic [2:0] {
        TX_DISABLED,    // Line idle, no grants taken
        TX_IDLE,        // Ready for the next byte
        TX_START_BIT,
        TX_DATA,
        TX_PARITY,
        TX_STOP_BIT
    } tx_state_t;

    // Receiver FSM
    typedef enum logic [2:0] {
        RX_IDLE,        // Waiting for a falling edge
        RX_START,       // Checking start bit at mid-point
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_t;

endpackage

// File: verilog/uart_frame_pkg.sv
package uart_frame_pkg;

    // One payload byte, sent LSB first
    typedef logic [7:0] data_byte_t;

    // Received frame after all ten post-start samples
    // Bits shift in at the top, so the first data bit ends at bit 0
    typedef struct packed {
        logic       stop;       // Last bit on the line
        logic       parity;     // Even parity over data
        data_byte_t data;       // data[0] arrived first
    } rx_frame_fields_t;

    // Same ten bits seen as a shift word or as frame fields
    typedef union packed {
        logic [9:0]       raw;      // Shift register view
        rx_frame_fields_t fields;   // Decoded view
    } rx_frame_t;

endpackage

// File: verilog/uart_link.sv
`timescale 1ns/10ps
`include "uart_config.svh"

module uart_link (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [2:0]                    baud_select,
    input  logic                          tx_enable,
    input  logic [`UART_NUM_CHANNELS-1:0] wr,        // Per-channel write strobe
    input  uart_frame_pkg::data_byte_t    wr_data [`UART_NUM_CHANNELS],
    output logic [`UART_NUM_CHANNELS-1:0] overrun,
    output logic                          txd,
    output logic                          tx_busy,
    input  logic                          rxd,
    output logic                          rx_valid,
    output uart_frame_pkg::data_byte_t    rx_data,
    output logic                          rx_parity_err,
    output logic                          rx_frame_err
);
    import uart_frame_pkg::*;

    logic                          os_tick;       // Shared by both directions
    logic [`UART_NUM_CHANNELS-1:0] full;
    logic [`UART_NUM_CHANNELS-1:0] grant;
    data_byte_t                    held_data [`UART_NUM_CHANNELS];
    logic                          tx_ready;
    logic                          tx_load;
    data_byte_t                    tx_data;       // Granted byte

    baud_gen baud_gen_inst (
        .clk         (clk),
        .reset       (reset),
        .baud_select (baud_select),
        .os_tick     (os_tick)
    );

    // One holding slot per host
    for (genvar i = 0; i < `UART_NUM_CHANNELS; i++) begin : gen_chan
        tx_channel tx_channel_inst (
            .clk       (clk),
            .reset     (reset),
            .wr        (wr[i]),
            .wr_data   (wr_data[i]),
            .grant     (grant[i]),
            .full      (full[i]),
            .held_data (held_data[i]),
            .overrun   (overrun[i])
        );
    end

    tx_arbiter tx_arbiter_inst (
        .clk       (clk),
        .reset     (reset),
        .full      (full),
        .held_data (held_data),
        .tx_ready  (tx_ready),
        .grant     (grant),
        .tx_load   (tx_load),
        .tx_data   (tx_data)
    );

    uart_tx uart_tx_inst (
        .clk       (clk),
        .reset     (reset),
        .os_tick   (os_tick),
        .tx_enable (tx_enable),
        .tx_load   (tx_load),
        .tx_data   (tx_data),
        .tx_ready  (tx_ready),
        .txd       (txd),
        .tx_busy   (tx_busy)
    );

    uart_rx uart_rx_inst (
        .clk           (clk),
        .reset         (reset),
        .os_tick       (os_tick),
        .rxd           (rxd),
        .rx_valid      (rx_valid),
        .rx_data       (rx_data),
        .rx_parity_err (rx_parity_err),
        .rx_frame_err  (rx_frame_err)
    );
endmodule

// File: verilog/uart_rx.sv
`timescale 1ns/10ps
`include "uart_config.svh"

module uart_rx (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       os_tick,        // 16x bit rate
    input  logic                       rxd,            // Async serial input
    output logic                       rx_valid,       // One-cycle strobe
    output uart_frame_pkg::data_byte_t rx_data,
    output logic                       rx_parity_err,
    output logic                       rx_frame_err    // Stop bit sampled low
);
    import uart_ctrl_pkg::*;
    import uart_frame_pkg::*;

    localparam int TICK_W = $clog2(`UART_OS_RATIO);

    rx_state_t         state;
    rx_frame_t         frame_q;     // Samples after the start bit
    logic              rxd_meta;    // First sync stage
    logic              rxd_sync;
    logic              rxd_prev;    // For falling edge detect
    logic [TICK_W-1:0] tick_cnt;
    logic [2:0]        bit_idx;     // Data bits taken
    logic              mid_start;   // Half a bit into the start bit
    logic              mid_bit;     // Middle of a later bit

    assign mid_start = os_tick && (tick_cnt == TICK_W'(`UART_OS_RATIO / 2 - 1));
    assign mid_bit   = os_tick && (tick_cnt == TICK_W'(`UART_OS_RATIO - 1));

    // Two-flop synchronizer, line idles high
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (os_tick)
                tick_cnt <= tick_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    bit_idx  <= '0;
                    if (rxd_prev && !rxd_sync)
                        state <= RX_START;     // Falling edge
                end
                RX_START: begin
                    if (mid_start) begin
                        tick_cnt <= '0;        // Re-center on bit middle
                        state    <= rxd_sync ? RX_IDLE : RX_DATA;  // High means glitch
                    end
                end
                RX_DATA: begin
                    if (mid_bit) begin
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7)
                            state <= RX_PARITY;
                    end
                end
                RX_PARITY: begin
                    if (mid_bit)
                        state <= RX_STOP;
                end
                RX_STOP: begin
                    if (mid_bit) begin
                        rx_valid <= 1'b1;      // Fields decoded next cycle
                        state    <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Shift each mid-bit sample in at the top
    always_ff @(posedge clk) begin
        if (mid_bit && (state == RX_DATA || state == RX_PARITY || state == RX_STOP))
            frame_q.raw <= {rxd_sync, frame_q.raw[9:1]};
    end

    // Field decode
    assign rx_data       = frame_q.fields.data;
    assign rx_parity_err = rx_valid & (frame_q.fields.parity ^ (^frame_q.fields.data));
    assign rx_frame_err  = rx_valid & ~frame_q.fields.stop;
endmodule

// File: verilog/uart_tx.sv
`timescale 1ns/10ps
`include "uart_config.svh"

module uart_tx (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       os_tick,     // 16x bit rate
    input  logic                       tx_enable,
    input  logic                       tx_load,     // Granted byte on tx_data
    input  uart_frame_pkg::data_byte_t tx_data,
    output logic                       tx_ready,
    output logic                       txd,         // Serial line, idles high
    output logic                       tx_busy
);
    import uart_ctrl_pkg::*;
    import uart_frame_pkg::*;

    localparam int TICK_W = $clog2(`UART_OS_RATIO);

    tx_state_t         state;
    tx_state_t         next_state;
    data_byte_t        data_q;      // Byte being sent
    logic [TICK_W-1:0] tick_cnt;    // Ticks into current bit
    logic [2:0]        bit_idx;     // Data bit on the line
    logic              bit_end;     // Last tick of current bit

    assign bit_end  = os_tick && (tick_cnt == TICK_W'(`UART_OS_RATIO - 1));
    assign tx_ready = (state == TX_IDLE) && tx_enable;

    always_comb begin
        next_state = state;
        case (state)
            TX_DISABLED: begin
                if (tx_enable)
                    next_state = TX_IDLE;
            end
            TX_IDLE: begin
                if (tx_load)
                    next_state = TX_START_BIT;
                else if (!tx_enable)
                    next_state = TX_DISABLED;
            end
            TX_START_BIT: begin
                if (bit_end)
                    next_state = TX_DATA;
            end
            TX_DATA: begin
                if (bit_end && bit_idx == 3'd7)
                    next_state = TX_PARITY;
            end
            TX_PARITY: begin
                if (bit_end)
                    next_state = TX_STOP_BIT;
            end
            TX_STOP_BIT: begin
                if (bit_end)
                    next_state = tx_enable ? TX_IDLE : TX_DISABLED;  // Frame always completes
            end
            default: next_state = TX_DISABLED;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            state <= TX_DISABLED;
        else
            state <= next_state;
    end

    // Bit timing
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tick_cnt <= '0;
            bit_idx  <= '0;
        end else if (state == TX_IDLE || state == TX_DISABLED) begin
            tick_cnt <= '0;
            bit_idx  <= '0;
        end else if (os_tick) begin
            if (bit_end) begin
                tick_cnt <= '0;
                if (state == TX_DATA)
                    bit_idx <= bit_idx + 3'd1;  // Wraps to 0 after bit 7
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tx_load && state == TX_IDLE)
            data_q <= tx_data;
    end

    // Line driven from a flop, one clock behind the state
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            txd     <= 1'b1;
            tx_busy <= 1'b0;
        end else begin
            tx_busy <= (state != TX_IDLE) && (state != TX_DISABLED);
            case (state)
                TX_START_BIT: txd <= 1'b0;
                TX_DATA:      txd <= data_q[bit_idx];
                TX_PARITY:    txd <= ^data_q;      // Even parity
                default:      txd <= 1'b1;         // Stop bit and idle
            endcase
        end
    end
endmodule

// File: vlog.f
+incdir+verilog
verilog/uart_frame_pkg.sv
verilog/uart_ctrl_pkg.sv
verilog/baud_gen.sv
verilog/tx_channel.sv
verilog/tx_arbiter.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_link.sv
test/uart_link_tb.sv
